/* design/axi_pkg.sv */
`default_nettype none

package axi_pkg;

    // bus field widths
    localparam int ID_WIDTH   = 4;
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    // fixed AXI3 field sizes
    localparam int LEN_WIDTH   = 4;
    localparam int SIZE_WIDTH  = 3;
    localparam int LOCK_WIDTH  = 2;
    localparam int CACHE_WIDTH = 4;
    localparam int PROT_WIDTH  = 3;

    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } burst_e;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_e;

    // shared by aw and ar
    typedef struct packed {
        logic [ID_WIDTH-1:0]    id;
        logic [ADDR_WIDTH-1:0]  addr;
        logic [LEN_WIDTH-1:0]   len;
        logic [SIZE_WIDTH-1:0]  size;
        burst_e                 burst;
        logic [LOCK_WIDTH-1:0]  lock;
        logic [CACHE_WIDTH-1:0] cache;
        logic [PROT_WIDTH-1:0]  prot;
    } addr_chan_t;

    typedef struct packed {
        logic [ID_WIDTH-1:0]   id;
        logic [DATA_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0] strb;
        logic                  last;
    } wdata_chan_t;

    typedef struct packed {
        logic [ID_WIDTH-1:0] id;
        resp_e               resp;
    } bresp_chan_t;

    typedef struct packed {
        logic [ID_WIDTH-1:0]   id;
        logic [DATA_WIDTH-1:0] data;
        resp_e                 resp;
        logic                  last;
    } rdata_chan_t;

endpackage

`default_nettype wire

/* design/xbar_pkg.sv */
`default_nettype none

package xbar_pkg;

    // largest master or slave count
    localparam int MAX_PORTS = 4;
    localparam int SEL_BITS  = $clog2(MAX_PORTS);

    typedef logic [SEL_BITS-1:0] port_idx_t;

    // one route from the external controller
    typedef struct packed {
        logic      en;
        port_idx_t sel;
    } route_t;

    // route enabled and pointing at idx
    function automatic logic route_hit(route_t route, port_idx_t idx);
        return route.en && (route.sel == idx);
    endfunction

endpackage

`default_nettype wire

/* design/req_router.sv */
`timescale 1ns/1ps
`default_nettype none

module req_router #(
    parameter int  NUM_MASTERS = 2,
    parameter int  NUM_SLAVES  = 2,
    parameter type payload_t   = logic
) (
    input  payload_t            src_data  [NUM_MASTERS],
    input  logic [NUM_MASTERS-1:0] src_valid,
    input  xbar_pkg::route_t    src_route [NUM_MASTERS],
    output logic [NUM_MASTERS-1:0] src_ready,
    output payload_t            dst_data  [NUM_SLAVES],
    output logic [NUM_SLAVES-1:0]  dst_valid,
    output xbar_pkg::port_idx_t dst_src   [NUM_SLAVES],
    input  logic [NUM_SLAVES-1:0]  dst_ready
);

    import xbar_pkg::*;

    // whether each slave is targeted and by which master
    logic [NUM_SLAVES-1:0] found;
    port_idx_t             win [NUM_SLAVES];

    // walk masters high to low so the lowest index lands last
    always_comb begin
        for (int s = 0; s < NUM_SLAVES; s++) begin
            found[s]     = 1'b0;
            win[s]       = '0;
            dst_data[s]  = '0;
            dst_valid[s] = 1'b0;
            for (int m = NUM_MASTERS - 1; m >= 0; m--) begin
                if (route_hit(src_route[m], port_idx_t'(s))) begin
                    found[s]     = 1'b1;
                    win[s]       = port_idx_t'(m);
                    dst_data[s]  = src_data[m];
                    dst_valid[s] = src_valid[m];
                end
            end
        end
    end

    always_comb begin
        for (int s = 0; s < NUM_SLAVES; s++) begin
            dst_src[s] = win[s];
        end
    end

    // a master sees ready only from the slave it won
    always_comb begin
        for (int m = 0; m < NUM_MASTERS; m++) begin
            src_ready[m] = 1'b0;
            for (int s = 0; s < NUM_SLAVES; s++) begin
                if (found[s] && (win[s] == port_idx_t'(m))) begin
                    src_ready[m] = dst_ready[s];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/resp_router.sv */
`timescale 1ns/1ps
`default_nettype none

module resp_router #(
    parameter int  NUM_SLAVES  = 2,
    parameter int  NUM_MASTERS = 2,
    parameter type payload_t   = logic
) (
    input  payload_t               src_data  [NUM_SLAVES],
    input  logic [NUM_SLAVES-1:0]  src_valid,
    input  xbar_pkg::route_t       src_route [NUM_SLAVES],
    output logic [NUM_SLAVES-1:0]  src_ready,
    output payload_t               dst_data  [NUM_MASTERS],
    output logic [NUM_MASTERS-1:0] dst_valid,
    input  logic [NUM_MASTERS-1:0] dst_ready
);

    import xbar_pkg::*;

    // winning slave per master
    logic [NUM_MASTERS-1:0] found;
    port_idx_t              win [NUM_MASTERS];

    // lowest slave index takes the master
    always_comb begin
        for (int m = 0; m < NUM_MASTERS; m++) begin
            found[m]     = 1'b0;
            win[m]       = '0;
            dst_data[m]  = '0;
            dst_valid[m] = 1'b0;
            for (int s = NUM_SLAVES - 1; s >= 0; s--) begin
                if (route_hit(src_route[s], port_idx_t'(m))) begin
                    found[m]     = 1'b1;
                    win[m]       = port_idx_t'(s);
                    dst_data[m]  = src_data[s];
                    dst_valid[m] = src_valid[s];
                end
            end
        end
    end

    // selected master's ready goes back to the winning slave only
    always_comb begin
        for (int s = 0; s < NUM_SLAVES; s++) begin
            src_ready[s] = 1'b0;
            for (int m = 0; m < NUM_MASTERS; m++) begin
                if (found[m] && (win[m] == port_idx_t'(s))) begin
                    src_ready[s] = dst_ready[m];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/axi_xbar_top.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_xbar_top #(
    parameter int NUM_MASTERS = 2,
    parameter int NUM_SLAVES  = 2
) (
    // master side write address
    input  axi_pkg::addr_chan_t    m_aw       [NUM_MASTERS],
    input  logic [NUM_MASTERS-1:0] m_aw_valid,
    input  xbar_pkg::route_t       m_aw_route [NUM_MASTERS],
    output logic [NUM_MASTERS-1:0] m_aw_ready,

    // master side write data
    input  axi_pkg::wdata_chan_t   m_w        [NUM_MASTERS],
    input  logic [NUM_MASTERS-1:0] m_w_valid,
    input  xbar_pkg::route_t       m_w_route  [NUM_MASTERS],
    output logic [NUM_MASTERS-1:0] m_w_ready,

    // master side read address
    input  axi_pkg::addr_chan_t    m_ar       [NUM_MASTERS],
    input  logic [NUM_MASTERS-1:0] m_ar_valid,
    input  xbar_pkg::route_t       m_ar_route [NUM_MASTERS],
    output logic [NUM_MASTERS-1:0] m_ar_ready,

    // slave side write address
    output axi_pkg::addr_chan_t    s_aw       [NUM_SLAVES],
    output logic [NUM_SLAVES-1:0]  s_aw_valid,
    output xbar_pkg::port_idx_t    s_aw_src   [NUM_SLAVES],
    input  logic [NUM_SLAVES-1:0]  s_aw_ready,

    // slave side write data
    output axi_pkg::wdata_chan_t   s_w        [NUM_SLAVES],
    output logic [NUM_SLAVES-1:0]  s_w_valid,
    output xbar_pkg::port_idx_t    s_w_src    [NUM_SLAVES],
    input  logic [NUM_SLAVES-1:0]  s_w_ready,

    // slave side read address
    output axi_pkg::addr_chan_t    s_ar       [NUM_SLAVES],
    output logic [NUM_SLAVES-1:0]  s_ar_valid,
    output xbar_pkg::port_idx_t    s_ar_src   [NUM_SLAVES],
    input  logic [NUM_SLAVES-1:0]  s_ar_ready,

    // write response
    input  axi_pkg::bresp_chan_t   s_b        [NUM_SLAVES],
    input  logic [NUM_SLAVES-1:0]  s_b_valid,
    input  xbar_pkg::route_t       s_b_route  [NUM_SLAVES],
    output logic [NUM_SLAVES-1:0]  s_b_ready,
    output axi_pkg::bresp_chan_t   m_b        [NUM_MASTERS],
    output logic [NUM_MASTERS-1:0] m_b_valid,
    input  logic [NUM_MASTERS-1:0] m_b_ready,

    // read data
    input  axi_pkg::rdata_chan_t   s_r        [NUM_SLAVES],
    input  logic [NUM_SLAVES-1:0]  s_r_valid,
    input  xbar_pkg::route_t       s_r_route  [NUM_SLAVES],
    output logic [NUM_SLAVES-1:0]  s_r_ready,
    output axi_pkg::rdata_chan_t   m_r        [NUM_MASTERS],
    output logic [NUM_MASTERS-1:0] m_r_valid,
    input  logic [NUM_MASTERS-1:0] m_r_ready
);

    import axi_pkg::*;

    // request channels routed by the masters
    req_router #(
        .NUM_MASTERS (NUM_MASTERS),
        .NUM_SLAVES  (NUM_SLAVES),
        .payload_t   (addr_chan_t)
    ) u_aw_router (
        .src_data  (m_aw),
        .src_valid (m_aw_valid),
        .src_route (m_aw_route),
        .src_ready (m_aw_ready),
        .dst_data  (s_aw),
        .dst_valid (s_aw_valid),
        .dst_src   (s_aw_src),
        .dst_ready (s_aw_ready)
    );

    req_router #(
        .NUM_MASTERS (NUM_MASTERS),
        .NUM_SLAVES  (NUM_SLAVES),
        .payload_t   (wdata_chan_t)
    ) u_w_router (
        .src_data  (m_w),
        .src_valid (m_w_valid),
        .src_route (m_w_route),
        .src_ready (m_w_ready),
        .dst_data  (s_w),
        .dst_valid (s_w_valid),
        .dst_src   (s_w_src),
        .dst_ready (s_w_ready)
    );

    // ar has its own route independent of aw
    req_router #(
        .NUM_MASTERS (NUM_MASTERS),
        .NUM_SLAVES  (NUM_SLAVES),
        .payload_t   (addr_chan_t)
    ) u_ar_router (
        .src_data  (m_ar),
        .src_valid (m_ar_valid),
        .src_route (m_ar_route),
        .src_ready (m_ar_ready),
        .dst_data  (s_ar),
        .dst_valid (s_ar_valid),
        .dst_src   (s_ar_src),
        .dst_ready (s_ar_ready)
    );

    // response channels routed by the slaves
    resp_router #(
        .NUM_SLAVES  (NUM_SLAVES),
        .NUM_MASTERS (NUM_MASTERS),
        .payload_t   (bresp_chan_t)
    ) u_b_router (
        .src_data  (s_b),
        .src_valid (s_b_valid),
        .src_route (s_b_route),
        .src_ready (s_b_ready),
        .dst_data  (m_b),
        .dst_valid (m_b_valid),
        .dst_ready (m_b_ready)
    );

    resp_router #(
        .NUM_SLAVES  (NUM_SLAVES),
        .NUM_MASTERS (NUM_MASTERS),
        .payload_t   (rdata_chan_t)
    ) u_r_router (
        .src_data  (s_r),
        .src_valid (s_r_valid),
        .src_route (s_r_route),
        .src_ready (s_r_ready),
        .dst_data  (m_r),
        .dst_valid (m_r_valid),
        .dst_ready (m_r_ready)
    );

endmodule

`default_nettype wire

/* verification/tb_axi_xbar.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_axi_xbar;

    import axi_pkg::*;
    import xbar_pkg::*;

    // same port count on both sides
    localparam int NUM_PORTS      = 2;
    localparam int RUN_CYCLES     = 2000;
    localparam int TIMEOUT_CYCLES = RUN_CYCLES + 200;

    logic   aclk = 1'b0;
    logic   rst_n;
    integer seed = 32'h5d7e;
    bit     run_done = 1'b0;
    int     idle_checks = 0;
    int     req_contention = 0;
    int     resp_contention = 0;

    addr_chan_t             m_aw [NUM_PORTS];
    logic [NUM_PORTS-1:0]   m_aw_valid;
    route_t                 m_aw_route [NUM_PORTS];
    logic [NUM_PORTS-1:0]   m_aw_ready;
    wdata_chan_t            m_w [NUM_PORTS];
    logic [NUM_PORTS-1:0]   m_w_valid;
    route_t                 m_w_route [NUM_PORTS];
    logic [NUM_PORTS-1:0]   m_w_ready;
    addr_chan_t             m_ar [NUM_PORTS];
    logic [NUM_PORTS-1:0]   m_ar_valid;
    route_t                 m_ar_route [NUM_PORTS];
    logic [NUM_PORTS-1:0]   m_ar_ready;

    addr_chan_t             s_aw [NUM_PORTS];
    logic [NUM_PORTS-1:0]   s_aw_valid;
    port_idx_t              s_aw_src [NUM_PORTS];
    logic [NUM_PORTS-1:0]   s_aw_ready;
    wdata_chan_t            s_w [NUM_PORTS];
    logic [NUM_PORTS-1:0]   s_w_valid;
    port_idx_t              s_w_src [NUM_PORTS];
    logic [NUM_PORTS-1:0]   s_w_ready;
    addr_chan_t             s_ar [NUM_PORTS];
    logic [NUM_PORTS-1:0]   s_ar_valid;
    port_idx_t              s_ar_src [NUM_PORTS];
    logic [NUM_PORTS-1:0]   s_ar_ready;

    bresp_chan_t            s_b [NUM_PORTS];
    logic [NUM_PORTS-1:0]   s_b_valid;
    route_t                 s_b_route [NUM_PORTS];
    logic [NUM_PORTS-1:0]   s_b_ready;
    bresp_chan_t            m_b [NUM_PORTS];
    logic [NUM_PORTS-1:0]   m_b_valid;
    logic [NUM_PORTS-1:0]   m_b_ready;
    rdata_chan_t            s_r [NUM_PORTS];
    logic [NUM_PORTS-1:0]   s_r_valid;
    route_t                 s_r_route [NUM_PORTS];
    logic [NUM_PORTS-1:0]   s_r_ready;
    rdata_chan_t            m_r [NUM_PORTS];
    logic [NUM_PORTS-1:0]   m_r_valid;
    logic [NUM_PORTS-1:0]   m_r_ready;

    // payloads widened to one width for the generic checker
    logic [63:0] aw_in [NUM_PORTS];
    logic [63:0] aw_out [NUM_PORTS];
    logic [63:0] w_in [NUM_PORTS];
    logic [63:0] w_out [NUM_PORTS];
    logic [63:0] ar_in [NUM_PORTS];
    logic [63:0] ar_out [NUM_PORTS];
    logic [63:0] b_in [NUM_PORTS];
    logic [63:0] b_out [NUM_PORTS];
    logic [63:0] r_in [NUM_PORTS];
    logic [63:0] r_out [NUM_PORTS];
    port_idx_t   no_src [NUM_PORTS] = '{default: '0};

    axi_xbar_top #(
        .NUM_MASTERS (NUM_PORTS),
        .NUM_SLAVES  (NUM_PORTS)
    ) UUT (
        .m_aw (m_aw), .m_aw_valid (m_aw_valid), .m_aw_route (m_aw_route), .m_aw_ready (m_aw_ready),
        .m_w  (m_w),  .m_w_valid  (m_w_valid),  .m_w_route  (m_w_route),  .m_w_ready  (m_w_ready),
        .m_ar (m_ar), .m_ar_valid (m_ar_valid), .m_ar_route (m_ar_route), .m_ar_ready (m_ar_ready),
        .s_aw (s_aw), .s_aw_valid (s_aw_valid), .s_aw_src   (s_aw_src),   .s_aw_ready (s_aw_ready),
        .s_w  (s_w),  .s_w_valid  (s_w_valid),  .s_w_src    (s_w_src),    .s_w_ready  (s_w_ready),
        .s_ar (s_ar), .s_ar_valid (s_ar_valid), .s_ar_src   (s_ar_src),   .s_ar_ready (s_ar_ready),
        .s_b  (s_b),  .s_b_valid  (s_b_valid),  .s_b_route  (s_b_route),  .s_b_ready  (s_b_ready),
        .m_b  (m_b),  .m_b_valid  (m_b_valid),  .m_b_ready  (m_b_ready),
        .s_r  (s_r),  .s_r_valid  (s_r_valid),  .s_r_route  (s_r_route),  .s_r_ready  (s_r_ready),
        .m_r  (m_r),  .m_r_valid  (m_r_valid),  .m_r_ready  (m_r_ready)
    );

    always #20 aclk = ~aclk;

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            aw_in[i]  = 64'(m_aw[i]);
            aw_out[i] = 64'(s_aw[i]);
            w_in[i]   = 64'(m_w[i]);
            w_out[i]  = 64'(s_w[i]);
            ar_in[i]  = 64'(m_ar[i]);
            ar_out[i] = 64'(s_ar[i]);
            b_in[i]   = 64'(s_b[i]);
            b_out[i]  = 64'(m_b[i]);
            r_in[i]   = 64'(s_r[i]);
            r_out[i]  = 64'(m_r[i]);
        end
    end

    task automatic value_error(input string name, input logic [63:0] exp, input logic [63:0] act);
        $display("ERROR at %0d ns: %s expected %0h actual %0h", $time, name, exp, act);
        $display("Simulation finished: FAIL");
        $fatal(1, "value mismatch on %s", name);
    endtask

    // first source routed to target or -1
    function automatic int lowest_requester(input route_t route [NUM_PORTS], input int target);
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (route[i].en && int'(route[i].sel) == target) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic bit has_contention(input route_t route [NUM_PORTS]);
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (route[i].en && int'(route[i].sel) < NUM_PORTS &&
                lowest_requester(route, int'(route[i].sel)) != i) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic bit all_routes_off();
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (m_aw_route[i].en || m_w_route[i].en || m_ar_route[i].en ||
                s_b_route[i].en || s_r_route[i].en) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // lowest routed source wins each destination of one channel
    task automatic check_channel(
        input string                src_name,
        input string                dst_name,
        input route_t               route [NUM_PORTS],
        input logic [NUM_PORTS-1:0] src_valid,
        input logic [NUM_PORTS-1:0] src_ready,
        input logic [63:0]          src_pay [NUM_PORTS],
        input logic [NUM_PORTS-1:0] dst_valid,
        input logic [NUM_PORTS-1:0] dst_ready,
        input logic [63:0]          dst_pay [NUM_PORTS],
        input port_idx_t            dst_src [NUM_PORTS],
        input bit                   check_src
    );
        int   win;
        int   tgt;
        logic exp_ready;
        for (int d = 0; d < NUM_PORTS; d++) begin
            win = lowest_requester(route, d);
            if (win < 0) begin
                assert (dst_valid[d] === 1'b0)
                    else value_error($sformatf("%s_valid[%0d]", dst_name, d), 0, 64'(dst_valid[d]));
                assert (dst_pay[d] === 64'd0)
                    else value_error($sformatf("%s[%0d]", dst_name, d), 0, dst_pay[d]);
            end else begin
                assert (dst_valid[d] === src_valid[win])
                    else value_error($sformatf("%s_valid[%0d]", dst_name, d),
                                     64'(src_valid[win]), 64'(dst_valid[d]));
                assert (dst_pay[d] === src_pay[win])
                    else value_error($sformatf("%s[%0d]", dst_name, d), src_pay[win], dst_pay[d]);
                if (check_src) begin
                    assert (int'(dst_src[d]) == win)
                        else value_error($sformatf("%s_src[%0d]", dst_name, d),
                                         64'(win), 64'(dst_src[d]));
                end
            end
        end
        for (int s = 0; s < NUM_PORTS; s++) begin
            exp_ready = 1'b0;
            tgt = int'(route[s].sel);
            if (route[s].en && tgt < NUM_PORTS && lowest_requester(route, tgt) == s) begin
                exp_ready = dst_ready[tgt];
            end
            assert (src_ready[s] === exp_ready)
                else value_error($sformatf("%s_ready[%0d]", src_name, s),
                                 64'(exp_ready), 64'(src_ready[s]));
        end
    endtask

    always @(negedge aclk) begin
        check_channel("m_aw", "s_aw", m_aw_route, m_aw_valid, m_aw_ready, aw_in,
                      s_aw_valid, s_aw_ready, aw_out, s_aw_src, 1'b1);
        check_channel("m_w", "s_w", m_w_route, m_w_valid, m_w_ready, w_in,
                      s_w_valid, s_w_ready, w_out, s_w_src, 1'b1);
        check_channel("m_ar", "s_ar", m_ar_route, m_ar_valid, m_ar_ready, ar_in,
                      s_ar_valid, s_ar_ready, ar_out, s_ar_src, 1'b1);
        check_channel("s_b", "m_b", s_b_route, s_b_valid, s_b_ready, b_in,
                      m_b_valid, m_b_ready, b_out, no_src, 1'b0);
        check_channel("s_r", "m_r", s_r_route, s_r_valid, s_r_ready, r_in,
                      m_r_valid, m_r_ready, r_out, no_src, 1'b0);
        if (all_routes_off()) begin
            assert (m_aw_ready === '0) else value_error("m_aw_ready", 0, 64'(m_aw_ready));
            assert (m_w_ready === '0) else value_error("m_w_ready", 0, 64'(m_w_ready));
            assert (m_ar_ready === '0) else value_error("m_ar_ready", 0, 64'(m_ar_ready));
            assert (s_aw_valid === '0) else value_error("s_aw_valid", 0, 64'(s_aw_valid));
            assert (s_w_valid === '0) else value_error("s_w_valid", 0, 64'(s_w_valid));
            assert (s_ar_valid === '0) else value_error("s_ar_valid", 0, 64'(s_ar_valid));
            assert (s_b_ready === '0) else value_error("s_b_ready", 0, 64'(s_b_ready));
            assert (s_r_ready === '0) else value_error("s_r_ready", 0, 64'(s_r_ready));
            assert (m_b_valid === '0) else value_error("m_b_valid", 0, 64'(m_b_valid));
            assert (m_r_valid === '0) else value_error("m_r_valid", 0, 64'(m_r_valid));
            if (rst_n) begin
                idle_checks++;
            end
        end
        if (rst_n && has_contention(m_aw_route)) begin
            req_contention++;
        end
        if (rst_n && has_contention(s_r_route)) begin
            resp_contention++;
        end
    end

    function automatic logic [63:0] random_word();
        return {$random(seed), $random(seed)};
    endfunction

    // mostly enabled so sources often collide or select a missing port
    function automatic route_t pick_route(input bit idle);
        route_t     route;
        logic [63:0] rnd;
        rnd = random_word();
        route.en  = !idle && (rnd[1:0] != 2'b00);
        route.sel = port_idx_t'(rnd[5:4]);
        return route;
    endfunction

    task automatic drive_random(input bit idle);
        logic [63:0] rnd;
        for (int i = 0; i < NUM_PORTS; i++) begin
            m_aw_route[i] <= pick_route(idle);
            m_w_route[i]  <= pick_route(idle);
            m_ar_route[i] <= pick_route(idle);
            s_b_route[i]  <= pick_route(idle);
            s_r_route[i]  <= pick_route(idle);
            rnd = random_word();
            m_aw[i] <= rnd[$bits(addr_chan_t)-1:0];
            rnd = random_word();
            m_w[i] <= rnd[$bits(wdata_chan_t)-1:0];
            rnd = random_word();
            m_ar[i] <= rnd[$bits(addr_chan_t)-1:0];
            rnd = random_word();
            s_b[i] <= rnd[$bits(bresp_chan_t)-1:0];
            rnd = random_word();
            s_r[i] <= rnd[$bits(rdata_chan_t)-1:0];
        end
        rnd = random_word();
        {m_aw_valid, m_w_valid, m_ar_valid, s_b_valid, s_r_valid} <= rnd[5*NUM_PORTS-1:0];
        rnd = random_word();
        {s_aw_ready, s_w_ready, s_ar_ready, m_b_ready, m_r_ready} <= rnd[5*NUM_PORTS-1:0];
    endtask

    task automatic clear_inputs();
        for (int i = 0; i < NUM_PORTS; i++) begin
            m_aw[i]       <= '0;
            m_w[i]        <= '0;
            m_ar[i]       <= '0;
            s_b[i]        <= '0;
            s_r[i]        <= '0;
            m_aw_route[i] <= '0;
            m_w_route[i]  <= '0;
            m_ar_route[i] <= '0;
            s_b_route[i]  <= '0;
            s_r_route[i]  <= '0;
        end
        {m_aw_valid, m_w_valid, m_ar_valid, s_b_valid, s_r_valid} <= '0;
        {s_aw_ready, s_w_ready, s_ar_ready, m_b_ready, m_r_ready} <= '0;
    endtask

    initial begin
        int waited;
        waited = 0;
        while (!run_done) begin
            @(posedge aclk);
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                $display("timeout: random stimulus did not finish in %0d cycles", TIMEOUT_CYCLES);
                $display("Simulation finished: FAIL");
                $fatal(1, "timeout");
            end
        end
    end

    initial begin
        rst_n <= 1'b0;
        clear_inputs();
        repeat (10) @(posedge aclk);
        rst_n <= 1'b1;
        // a few all-off cycles every 50 for the idle check
        for (int cycle = 0; cycle < RUN_CYCLES; cycle++) begin
            @(posedge aclk);
            drive_random((cycle % 50) < 3);
        end
        // last beat is checked on this falling edge
        @(negedge aclk);
        @(posedge aclk);
        run_done = 1'b1;
        if (idle_checks > 0 && req_contention > 0 && resp_contention > 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("stimulus never reached the idle or contention checks");
            $display("Simulation finished: FAIL");
            $fatal(1, "incomplete stimulus");
        end
    end

endmodule

`default_nettype wire

/* sim.f */
design/axi_pkg.sv
design/xbar_pkg.sv
design/req_router.sv
design/resp_router.sv
design/axi_xbar_top.sv
verification/tb_axi_xbar.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

# --assert turns on the testbench's immediate assertions
verilator --binary --assert -j 0 --top-module tb_axi_xbar -f sim.f

# pass only if the testbench printed its pass line
./obj_dir/Vtb_axi_xbar | tee /dev/stderr | grep -x "Simulation finished: PASS" > /dev/null
echo "run.sh: simulation passed"
